/* vlog.f */
common/mem_pkg.sv
common/line_return_if.sv
common/word_push_if.sv
source/request_sequencer.sv
source/line_unpacker.sv
source/tx_word_fifo.sv
source/io_conversion_buffer.sv
bench/tb_clock_gen.sv
bench/tb_memory_responder.sv
bench/tb_io_conversion_buffer.sv

/* bench/tb_io_conversion_buffer.sv */
// --------------------------------------------------------------------------
// io conversion buffer testbench
// directed and random requests checked against a shadow of the memory
// --------------------------------------------------------------------------
module tb_io_conversion_buffer;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 200;

    logic                sys_clock;
    logic                sys_reset;
    logic                sys_req;
    logic                sys_block;
    logic                sys_rw;
    logic                sys_clear;
    mem_pkg::sys_addr_t  sys_addr;
    mem_pkg::word_t      sys_data;
    logic                sys_ready;
    logic                sys_valid;
    logic                sys_done;
    mem_pkg::word_t      sys_rdata;
    logic                s0_ready;
    logic                s0_rdata_valid;
    mem_pkg::line_t      s0_rdata;
    logic                s0_burstbegin;
    mem_pkg::line_addr_t s0_addr;
    mem_pkg::line_t      s0_wdata;
    logic                s0_read_req;
    logic                s0_write_req;
    logic [mem_pkg::SIZE_WIDTH-1:0] s0_size;

    mem_pkg::line_t shadow [64];
    integer         seed;

    tb_clock_gen u_clock (
        .sys_clock_o (sys_clock),
        .sys_reset_o (sys_reset)
    );

    tb_memory_responder #(
        .SEED (51)
    ) u_memory (
        .sys_clock_i   (sys_clock),
        .sys_reset_i   (sys_reset),
        .read_req_i    (s0_read_req),
        .write_req_i   (s0_write_req),
        .addr_i        (s0_addr),
        .wdata_i       (s0_wdata),
        .ready_o       (s0_ready),
        .rdata_valid_o (s0_rdata_valid),
        .rdata_o       (s0_rdata)
    );

    io_conversion_buffer #(
        .TX_DEPTH (16)
    ) dut0 (
        .sys_clock_i      (sys_clock),
        .sys_reset_i      (sys_reset),
        .sys_req_i        (sys_req),
        .sys_block_i      (sys_block),
        .sys_rw_i         (sys_rw),
        .sys_clear_i      (sys_clear),
        .sys_addr_i       (sys_addr),
        .sys_data_i       (sys_data),
        .sys_ready_o      (sys_ready),
        .sys_valid_o      (sys_valid),
        .sys_done_o       (sys_done),
        .sys_data_o       (sys_rdata),
        .s0_ready_i       (s0_ready),
        .s0_rdata_valid_i (s0_rdata_valid),
        .s0_rdata_i       (s0_rdata),
        .s0_burstbegin_o  (s0_burstbegin),
        .s0_addr_o        (s0_addr),
        .s0_wdata_o       (s0_wdata),
        .s0_read_req_o    (s0_read_req),
        .s0_write_req_o   (s0_write_req),
        .s0_size_o        (s0_size)
    );

    // --------------------------------------------------------------------------
    // failure reporting and compares
    // --------------------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input mem_pkg::word_t expected,
                              input mem_pkg::word_t actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_line(input string name, input mem_pkg::line_t expected,
                              input mem_pkg::line_t actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_line_addr(input string name, input mem_pkg::line_addr_t expected,
                                   input mem_pkg::line_addr_t actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_size(input string name,
                              input logic [mem_pkg::SIZE_WIDTH-1:0] expected,
                              input logic [mem_pkg::SIZE_WIDTH-1:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERROR %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (expected != actual) begin
            abort_run($sformatf("ERROR %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    // one lane of a shadow line, memory index is the low six line bits
    function automatic mem_pkg::word_t shadow_lane(input mem_pkg::line_addr_t line, input int lane);
        return shadow[line[5:0]][lane*mem_pkg::WORD_WIDTH +: mem_pkg::WORD_WIDTH];
    endfunction

    // --------------------------------------------------------------------------
    // one request from acceptance through done and clear
    // --------------------------------------------------------------------------
    task automatic run_request(input string name, input logic block, input logic rw,
                               input mem_pkg::sys_addr_t addr, input mem_pkg::word_t data);
        mem_pkg::line_addr_t line_a;
        mem_pkg::line_t      exp_line;
        mem_pkg::word_t      words [$];
        mem_pkg::line_addr_t reads [$];
        int                  cycles;
        int                  writes;
        logic                accepted;
        line_a = {1'b0, addr[mem_pkg::SYS_ADDR_WIDTH-1:3]};
        sys_req <= 1'b1;
        sys_block <= block;
        sys_rw <= rw;
        sys_addr <= addr;
        sys_data <= data;
        accepted = 1'b0;
        cycles = 0;
        while (!accepted) begin
            @(posedge sys_clock);
            accepted = sys_req && sys_ready;
            cycles++;
            if (!accepted && cycles > TIMEOUT) begin
                abort_run({name, ": request was never accepted"});
            end
        end
        sys_req <= 1'b0;
        cycles = 0;
        writes = 0;
        do begin
            @(posedge sys_clock);
            cycles++;
            if (sys_valid) begin
                words.push_back(sys_rdata);
            end
            if (cycles == 1 && !s0_read_req) begin
                abort_run({name, ": no read pulse in the cycle after acceptance"});
            end
            // only the first read may go out without Avalon ready
            if (cycles > 1 && (s0_read_req || s0_write_req) && !s0_ready) begin
                abort_run({name, ": Avalon request issued while ready was low"});
            end
            if (s0_burstbegin !== (s0_read_req || s0_write_req)) begin
                abort_run({name, ": burst begin does not match the request pulses"});
            end
            // every access is a single-beat burst
            if (s0_burstbegin) begin
                check_size({name, " burst size"}, 10'd1, s0_size);
            end
            if (s0_read_req) begin
                reads.push_back(s0_addr);
            end
            if (s0_write_req) begin
                writes++;
                exp_line = shadow[line_a[5:0]];
                exp_line[addr[2:0]*mem_pkg::WORD_WIDTH +: mem_pkg::WORD_WIDTH] = data;
                check_line_addr({name, " write address"}, line_a, s0_addr);
                check_line({name, " write data"}, exp_line, s0_wdata);
                shadow[line_a[5:0]] = exp_line;
            end
            if (!sys_done && cycles > TIMEOUT) begin
                abort_run({name, ": done was never raised"});
            end
        end while (!sys_done);

        // pulses seen before done
        check_count({name, " read pulses"}, block ? 2 : 1, reads.size());
        check_count({name, " write pulses"}, (rw && !block) ? 1 : 0, writes);
        for (int i = 0; i < reads.size(); i++) begin
            check_line_addr({name, " read address"}, line_a + mem_pkg::line_addr_t'(i), reads[i]);
        end

        // every word must be out before done
        if (block) begin
            check_count({name, " word count"}, 16, words.size());
            for (int k = 0; k < 16; k++) begin
                check_word($sformatf("%s word %0d", name, k),
                           shadow_lane(line_a + mem_pkg::line_addr_t'(k / 8), k % 8), words[k]);
            end
        end else if (!rw) begin
            check_count({name, " word count"}, 1, words.size());
            check_word({name, " word"}, shadow_lane(line_a, int'(addr[2:0])), words[0]);
        end else begin
            check_count({name, " word count"}, 0, words.size());
        end

        sys_clear <= 1'b1;
        @(posedge sys_clock);
        sys_clear <= 1'b0;
        @(posedge sys_clock);
        if (sys_done) begin
            abort_run({name, ": done stayed high after clear"});
        end
    endtask

    // --------------------------------------------------------------------------
    // main sequence
    // --------------------------------------------------------------------------
    initial begin
        int                 cycles;
        int                 kind;
        mem_pkg::sys_addr_t addr;
        mem_pkg::word_t     data;
        seed = 51;
        sys_req = 1'b0;
        sys_block = 1'b0;
        sys_rw = 1'b0;
        sys_clear = 1'b0;
        sys_addr = '0;
        sys_data = '0;

        cycles = 0;
        do begin
            @(posedge sys_clock);
            cycles++;
            if (!sys_reset && cycles > TIMEOUT) begin
                abort_run("reset was never released");
            end
        end while (!sys_reset);
        if (sys_ready || sys_valid || sys_done || s0_read_req || s0_write_req ||
            s0_burstbegin) begin
            abort_run("outputs were not low after reset");
        end
        for (int i = 0; i < 64; i++) begin
            shadow[i] = u_memory.mem[i];
        end

        // ready must come up by itself while idle
        cycles = 0;
        while (!sys_ready) begin
            @(posedge sys_clock);
            cycles++;
            if (!sys_ready && cycles > TIMEOUT) begin
                abort_run("ready never rose after reset");
            end
        end

        run_request("single read", 1'b0, 1'b0, 27'h00000a5, 32'h0);
        run_request("single write", 1'b0, 1'b1, 27'h00000a5, 32'hdeadbeef);
        run_request("read after write", 1'b0, 1'b0, 27'h00000a5, 32'h0);
        run_request("block read", 1'b1, 1'b0, 27'h000013c, 32'h0);
        // second line wraps the model's index range
        run_request("block read wrap", 1'b1, 1'b0, 27'h00001fb, 32'h0);

        for (int n = 0; n < 200; n++) begin
            kind = {$random(seed)} % 3;
            addr = $random(seed);
            data = $random(seed);
            run_request($sformatf("random %0d", n), kind == 2, kind == 1, addr, data);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* bench/tb_memory_responder.sv */
// --------------------------------------------------------------------------
// Avalon memory model
// 64 random lines, read latency of 1 to 6 cycles, random ready stalls
// --------------------------------------------------------------------------
module tb_memory_responder #(
    parameter int SEED = 51
) (
    input  logic                sys_clock_i,
    input  logic                sys_reset_i,
    input  logic                read_req_i,
    input  logic                write_req_i,
    input  mem_pkg::line_addr_t addr_i,
    input  mem_pkg::line_t      wdata_i,
    output logic                ready_o,
    output logic                rdata_valid_o,
    output mem_pkg::line_t      rdata_o
);
    timeunit 1ns;
    timeprecision 100ps;

    mem_pkg::line_t mem [64];
    integer         seed;
    int             delay;
    logic [5:0]     pend_idx;

    initial begin
        seed = SEED;
        for (int i = 0; i < 64; i++) begin
            for (int w = 0; w < mem_pkg::WORDS_PER_LINE; w++) begin
                mem[i][w*mem_pkg::WORD_WIDTH +: mem_pkg::WORD_WIDTH] = $random(seed);
            end
        end
        ready_o = 1'b0;
        rdata_valid_o = 1'b0;
        rdata_o = '0;
        delay = 0;
        pend_idx = '0;
    end

    always @(posedge sys_clock_i) begin
        if (!sys_reset_i) begin
            ready_o <= 1'b0;
            rdata_valid_o <= 1'b0;
            delay <= 0;
        end else begin
            // ready high about three cycles in four
            ready_o <= (($random(seed) & 3) != 0);
            rdata_valid_o <= 1'b0;
            if (read_req_i) begin
                pend_idx <= addr_i[5:0];
                delay <= 1 + ({$random(seed)} % 6);
            end else if (delay == 1) begin
                rdata_valid_o <= 1'b1;
                rdata_o <= mem[pend_idx];
                delay <= 0;
            end else if (delay > 1) begin
                delay <= delay - 1;
            end
            if (write_req_i) begin
                mem[addr_i[5:0]] <= wdata_i;
            end
        end
    end

endmodule

/* bench/tb_clock_gen.sv */
// --------------------------------------------------------------------------
// testbench clock and reset
// 8 ns clock, active low reset held for the first two rising edges
// --------------------------------------------------------------------------
module tb_clock_gen (
    output logic sys_clock_o,
    output logic sys_reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        sys_clock_o = 1'b0;
        sys_reset_o = 1'b0;
        repeat (2) @(posedge sys_clock_o);
        sys_reset_o <= 1'b1;
    end

    always #4 sys_clock_o = ~sys_clock_o;

endmodule

/* source/io_conversion_buffer.sv */
// -------------------------------------------------------------------------
// io conversion buffer
// bridges a 32-bit processor request port to a 256-bit Avalon DDR3 port
// -------------------------------------------------------------------------
module io_conversion_buffer #(
    parameter int TX_DEPTH = 16
) (
    input  logic                              sys_clock_i,
    input  logic                              sys_reset_i,

    // processor side
    input  logic                              sys_req_i,
    input  logic                              sys_block_i,
    input  logic                              sys_rw_i,
    input  logic                              sys_clear_i,
    input  mem_pkg::sys_addr_t                sys_addr_i,
    input  mem_pkg::word_t                    sys_data_i,
    output logic                              sys_ready_o,
    output logic                              sys_valid_o,
    output logic                              sys_done_o,
    output mem_pkg::word_t                    sys_data_o,

    // Avalon DDR3 side
    input  logic                              s0_ready_i,
    input  logic                              s0_rdata_valid_i,
    input  mem_pkg::line_t                    s0_rdata_i,
    output logic                              s0_burstbegin_o,
    output mem_pkg::line_addr_t               s0_addr_o,
    output mem_pkg::line_t                    s0_wdata_o,
    output logic                              s0_read_req_o,
    output logic                              s0_write_req_o,
    output logic [mem_pkg::SIZE_WIDTH-1:0]    s0_size_o
);

    line_return_if ret_bus ();
    word_push_if   push_bus ();

    // every access is a single-beat burst
    assign s0_size_o = mem_pkg::BURST_SIZE;

    request_sequencer u_sequencer (
        .sys_clock_i      (sys_clock_i),
        .sys_reset_i      (sys_reset_i),
        .sys_req_i        (sys_req_i),
        .sys_block_i      (sys_block_i),
        .sys_rw_i         (sys_rw_i),
        .sys_clear_i      (sys_clear_i),
        .sys_addr_i       (sys_addr_i),
        .sys_data_i       (sys_data_i),
        .sys_ready_o      (sys_ready_o),
        .sys_done_o       (sys_done_o),
        .s0_ready_i       (s0_ready_i),
        .s0_rdata_valid_i (s0_rdata_valid_i),
        .s0_rdata_i       (s0_rdata_i),
        .s0_burstbegin_o  (s0_burstbegin_o),
        .s0_addr_o        (s0_addr_o),
        .s0_wdata_o       (s0_wdata_o),
        .s0_read_req_o    (s0_read_req_o),
        .s0_write_req_o   (s0_write_req_o),
        .tx_empty_i       (push_bus.empty),
        .ret_bus          (ret_bus.sender)
    );

    line_unpacker u_unpacker (
        .sys_clock_i      (sys_clock_i),
        .sys_reset_i      (sys_reset_i),
        .s0_rdata_valid_i (s0_rdata_valid_i),
        .s0_rdata_i       (s0_rdata_i),
        .ret_bus          (ret_bus.receiver),
        .push_bus         (push_bus.sender)
    );

    tx_word_fifo #(
        .TX_DEPTH (TX_DEPTH)
    ) u_tx_fifo (
        .sys_clock_i (sys_clock_i),
        .sys_reset_i (sys_reset_i),
        .push_bus    (push_bus.receiver),
        .sys_valid_o (sys_valid_o),
        .sys_data_o  (sys_data_o)
    );

endmodule

/* source/tx_word_fifo.sv */
// -------------------------------------------------------------------------
// transmit word buffer
// circular buffer drained one word per cycle onto the system data port
// -------------------------------------------------------------------------
module tx_word_fifo #(
    // power of two, at least 16
    parameter int TX_DEPTH = 16
) (
    input  logic           sys_clock_i,
    input  logic           sys_reset_i,
    word_push_if.receiver  push_bus,
    output logic           sys_valid_o,
    output mem_pkg::word_t sys_data_o
);

    localparam int PTR_WIDTH = $clog2(TX_DEPTH);
    localparam int LEVEL_WIDTH = $clog2(TX_DEPTH + 1);

    mem_pkg::word_t         mem_q [TX_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr_q;
    logic [PTR_WIDTH-1:0]   rd_ptr_q;
    logic [LEVEL_WIDTH-1:0] level_q;
    logic [LEVEL_WIDTH-1:0] push_words;
    logic                   pop;

    // with an empty buffer the first pushed word bypasses straight to the output
    assign pop = (level_q != '0) || push_bus.push;
    assign push_words = push_bus.push ? LEVEL_WIDTH'(push_bus.count) : '0;
    assign push_bus.empty = (level_q == '0) && !sys_valid_o && !push_bus.push;

    // storage
    always_ff @(posedge sys_clock_i) begin
        if (push_bus.push) begin
            for (int i = 0; i < mem_pkg::WORDS_PER_LINE; i++) begin
                if (i < push_bus.count) begin
                    mem_q[wr_ptr_q + PTR_WIDTH'(i)] <= push_bus.words[i];
                end
            end
        end
    end

    // pointers, level and output valid
    always_ff @(posedge sys_clock_i) begin
        if (!sys_reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q <= '0;
            sys_valid_o <= 1'b0;
        end else begin
            if (push_bus.push) begin
                wr_ptr_q <= wr_ptr_q + PTR_WIDTH'(push_bus.count);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            level_q <= level_q + push_words - LEVEL_WIDTH'(pop);
            sys_valid_o <= pop;
        end
    end

    // output word
    always_ff @(posedge sys_clock_i) begin
        if (pop) begin
            sys_data_o <= (level_q != '0) ? mem_q[rd_ptr_q] : push_bus.words[0];
        end
    end

endmodule

/* source/line_unpacker.sv */
// -------------------------------------------------------------------------
// line unpacker
// turns returned Avalon lines into one-word or eight-word buffer pushes
// -------------------------------------------------------------------------
module line_unpacker (
    input  logic            sys_clock_i,
    input  logic            sys_reset_i,
    input  logic            s0_rdata_valid_i,
    input  mem_pkg::line_t  s0_rdata_i,
    line_return_if.receiver ret_bus,
    word_push_if.sender     push_bus
);

    logic take_line;

    // write-fetch lines arrive with neither flag set and are ignored
    assign take_line = s0_rdata_valid_i && (ret_bus.expect_word || ret_bus.expect_line);
    assign ret_bus.taken = take_line;

    // push strobe
    always_ff @(posedge sys_clock_i) begin
        if (!sys_reset_i) begin
            push_bus.push <= 1'b0;
        end else begin
            push_bus.push <= take_line;
        end
    end

    // push payload
    always_ff @(posedge sys_clock_i) begin
        if (take_line) begin
            if (ret_bus.expect_word) begin
                // single word goes out in lane 0
                push_bus.words[0] <=
                    s0_rdata_i[ret_bus.sub_word*mem_pkg::WORD_WIDTH +: mem_pkg::WORD_WIDTH];
                push_bus.count <= mem_pkg::PUSH_COUNT_WIDTH'(1);
            end else begin
                push_bus.words <= s0_rdata_i;
                push_bus.count <= mem_pkg::PUSH_COUNT_WIDTH'(mem_pkg::WORDS_PER_LINE);
            end
        end
    end

endmodule

/* source/request_sequencer.sv */
// -------------------------------------------------------------------------
// request sequencer
// accepts system requests, issues Avalon read and write pulses, merges the
// write word into the fetched line and runs the done/clear handshake
// -------------------------------------------------------------------------
module request_sequencer (
    input  logic                 sys_clock_i,
    input  logic                 sys_reset_i,
    input  logic                 sys_req_i,
    input  logic                 sys_block_i,
    input  logic                 sys_rw_i,
    input  logic                 sys_clear_i,
    input  mem_pkg::sys_addr_t   sys_addr_i,
    input  mem_pkg::word_t       sys_data_i,
    output logic                 sys_ready_o,
    output logic                 sys_done_o,
    input  logic                 s0_ready_i,
    input  logic                 s0_rdata_valid_i,
    input  mem_pkg::line_t       s0_rdata_i,
    output logic                 s0_burstbegin_o,
    output mem_pkg::line_addr_t  s0_addr_o,
    output mem_pkg::line_t       s0_wdata_o,
    output logic                 s0_read_req_o,
    output logic                 s0_write_req_o,
    input  logic                 tx_empty_i,
    line_return_if.sender        ret_bus
);

    mem_pkg::seq_state_t state_q;
    logic                first_read_q;
    logic                accept;

    // request payload
    mem_pkg::line_addr_t line_addr_q;
    mem_pkg::sub_word_t  sub_word_q;
    mem_pkg::word_t      write_word_q;
    mem_pkg::line_t      line_q;
    mem_pkg::line_t      merged_line;

    assign accept = (state_q == mem_pkg::ST_IDLE) && sys_req_i && sys_ready_o;

    // fetched line with the addressed lane replaced
    always_comb begin
        merged_line = s0_rdata_i;
        merged_line[sub_word_q*mem_pkg::WORD_WIDTH +: mem_pkg::WORD_WIDTH] = write_word_q;
    end

    // -------------------------------------------------------------------------
    // Avalon request side
    // -------------------------------------------------------------------------
    // first read goes out the cycle after acceptance, later ones wait for ready
    assign s0_read_req_o = first_read_q ||
                           ((state_q == mem_pkg::ST_READ_BLOCK_REQUEST) && s0_ready_i);
    assign s0_write_req_o = (state_q == mem_pkg::ST_WRITE_ISSUE) && s0_ready_i;
    assign s0_burstbegin_o = s0_read_req_o || s0_write_req_o;
    assign s0_addr_o = line_addr_q;
    assign s0_wdata_o = line_q;

    // tell the unpacker what the next line is for
    assign ret_bus.expect_word = (state_q == mem_pkg::ST_READ_WORD);
    assign ret_bus.expect_line = (state_q == mem_pkg::ST_READ_BLOCK_FIRST) ||
                                 (state_q == mem_pkg::ST_READ_BLOCK_SECOND);
    assign ret_bus.sub_word = sub_word_q;

    // -------------------------------------------------------------------------
    // control FSM
    // -------------------------------------------------------------------------
    always_ff @(posedge sys_clock_i) begin
        if (!sys_reset_i) begin
            state_q <= mem_pkg::ST_IDLE;
            sys_ready_o <= 1'b0;
            sys_done_o <= 1'b0;
            first_read_q <= 1'b0;
        end else begin
            first_read_q <= 1'b0;
            case (state_q)
                mem_pkg::ST_IDLE: begin
                    sys_ready_o <= s0_ready_i && tx_empty_i;
                    if (accept) begin
                        sys_ready_o <= 1'b0;
                        first_read_q <= 1'b1;
                        // block requests are always reads
                        if (sys_block_i) begin
                            state_q <= mem_pkg::ST_READ_BLOCK_FIRST;
                        end else if (sys_rw_i) begin
                            state_q <= mem_pkg::ST_WRITE_FETCH;
                        end else begin
                            state_q <= mem_pkg::ST_READ_WORD;
                        end
                    end
                end
                mem_pkg::ST_READ_WORD: begin
                    if (ret_bus.taken) begin
                        state_q <= mem_pkg::ST_WAIT_CLEAR;
                    end
                end
                mem_pkg::ST_WRITE_FETCH: begin
                    if (s0_rdata_valid_i) begin
                        state_q <= mem_pkg::ST_WRITE_ISSUE;
                    end
                end
                mem_pkg::ST_WRITE_ISSUE: begin
                    // write pulse leaves this cycle, nothing was pushed
                    if (s0_ready_i) begin
                        sys_done_o <= tx_empty_i;
                        state_q <= mem_pkg::ST_WAIT_CLEAR;
                    end
                end
                mem_pkg::ST_READ_BLOCK_FIRST: begin
                    if (ret_bus.taken) begin
                        state_q <= mem_pkg::ST_READ_BLOCK_REQUEST;
                    end
                end
                mem_pkg::ST_READ_BLOCK_REQUEST: begin
                    if (s0_ready_i) begin
                        state_q <= mem_pkg::ST_READ_BLOCK_SECOND;
                    end
                end
                mem_pkg::ST_READ_BLOCK_SECOND: begin
                    if (ret_bus.taken) begin
                        state_q <= mem_pkg::ST_WAIT_CLEAR;
                    end
                end
                mem_pkg::ST_WAIT_CLEAR: begin
                    // done waits until every word has left the buffer
                    if (!sys_done_o) begin
                        sys_done_o <= tx_empty_i;
                    end else if (sys_clear_i) begin
                        sys_done_o <= 1'b0;
                        state_q <= mem_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state_q <= mem_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // address, lane and write data
    always_ff @(posedge sys_clock_i) begin
        if (accept) begin
            line_addr_q <= {1'b0, sys_addr_i[mem_pkg::SYS_ADDR_WIDTH-1:mem_pkg::SUB_WORD_WIDTH]};
            sub_word_q <= sys_addr_i[mem_pkg::SUB_WORD_WIDTH-1:0];
            write_word_q <= sys_data_i;
        end else if ((state_q == mem_pkg::ST_READ_BLOCK_FIRST) && ret_bus.taken) begin
            // second block line follows the first
            line_addr_q <= line_addr_q + 1'b1;
        end
        if ((state_q == mem_pkg::ST_WRITE_FETCH) && s0_rdata_valid_i) begin
            line_q <= merged_line;
        end
    end

endmodule

/* common/word_push_if.sv */
// -------------------------------------------------------------------------
// word push interface
// moves one or eight words per strobe into the transmit buffer
// -------------------------------------------------------------------------
interface word_push_if ();

    // one-cycle strobe, always accepted
    logic push;
    // number of valid words, 1 or 8
    logic [mem_pkg::PUSH_COUNT_WIDTH-1:0] count;
    // lane 0 in words[0]
    mem_pkg::word_t [mem_pkg::WORDS_PER_LINE-1:0] words;
    // buffer and output register hold nothing
    logic empty;

    modport sender (
        output push,
        output count,
        output words,
        input  empty
    );

    modport receiver (
        input  push,
        input  count,
        input  words,
        output empty
    );

endinterface

/* common/line_return_if.sv */
// -------------------------------------------------------------------------
// line return interface
// tells the unpacker what the next returned Avalon line is for
// -------------------------------------------------------------------------
interface line_return_if ();

    // next returned line serves a single-word read
    logic expect_word;
    // next returned line serves a block read
    logic expect_line;
    // lane picked for a single-word read
    mem_pkg::sub_word_t sub_word;
    // pulsed by the unpacker when it consumes a line
    logic taken;

    modport sender (
        output expect_word,
        output expect_line,
        output sub_word,
        input  taken
    );

    modport receiver (
        input  expect_word,
        input  expect_line,
        input  sub_word,
        output taken
    );

endinterface

/* common/mem_pkg.sv */
// -------------------------------------------------------------------------
// memory conversion package
// word, line and address sizes shared by the 32-bit system side and the
// 256-bit Avalon DDR3 side, plus the request sequencer state encoding
// -------------------------------------------------------------------------
package mem_pkg;

    // data sizes
    localparam int WORD_WIDTH = 32;
    localparam int LINE_WIDTH = 256;
    localparam int WORDS_PER_LINE = LINE_WIDTH / WORD_WIDTH;
    localparam int SUB_WORD_WIDTH = $clog2(WORDS_PER_LINE);

    // push count holds 1 up to WORDS_PER_LINE
    localparam int PUSH_COUNT_WIDTH = SUB_WORD_WIDTH + 1;

    // addressing
    localparam int SYS_ADDR_WIDTH = 27;
    // line address is the word address without the lane bits, plus one zero msb
    localparam int LINE_ADDR_WIDTH = SYS_ADDR_WIDTH - SUB_WORD_WIDTH + 1;

    // Avalon burst size, always one beat
    localparam int SIZE_WIDTH = 10;
    localparam logic [SIZE_WIDTH-1:0] BURST_SIZE = 10'd1;

    typedef logic [WORD_WIDTH-1:0]      word_t;
    typedef logic [LINE_WIDTH-1:0]      line_t;
    typedef logic [SUB_WORD_WIDTH-1:0]  sub_word_t;
    typedef logic [SYS_ADDR_WIDTH-1:0]  sys_addr_t;
    typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;

    // request sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_WORD,
        ST_WRITE_FETCH,
        ST_WRITE_ISSUE,
        ST_READ_BLOCK_FIRST,
        ST_READ_BLOCK_REQUEST,
        ST_READ_BLOCK_SECOND,
        ST_WAIT_CLEAR
    } seq_state_t;

endpackage
